/* common/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

//**********************************************************************
// Datapath widths
//**********************************************************************

// Address and load data width
`define LSU_ADDR_W 32

// Immediate offset carried with a core load/store
`define LSU_OFFSET_W 12

// DMA size code width
`define LSU_DMA_SZ_W 3

//**********************************************************************
// Memory map
//**********************************************************************

// DCCM window of 64 KB
`define LSU_DCCM_BASE 32'hF004_0000
`define LSU_DCCM_SIZE 32'h0001_0000

// PIC register window of 32 KB
`define LSU_PIC_BASE 32'hF00C_0000
`define LSU_PIC_SIZE 32'h0000_8000

`endif

/* common/lsu_pkg.sv */
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

   // Request packet with valid in bit 0
   typedef struct packed {
      logic dword;
      logic word;
      logic half;
      logic by;
      logic load;
      logic store;
      logic unsign;
      logic dma;
      logic valid;
   } lsu_pkt_t;

   // DC3 exception report to the core
   typedef struct packed {
      logic                   exc_valid;
      logic                   inst_type;   // 1 for a store
      logic                   exc_type;    // 0 misaligned, 1 access or bus fault
      logic [`LSU_ADDR_W-1:0] addr;
   } lsu_error_pkt_t;

   // Size code on the DMA port
   typedef enum logic [`LSU_DMA_SZ_W-1:0] {
      BYTE  = 3'd0,
      HALF  = 3'd1,
      WORD  = 3'd2,
      DWORD = 3'd3
   } lsu_dma_size_e;

endpackage

`default_nettype wire

/* common/lsu_map_pkg.sv */
`default_nettype none

package lsu_map_pkg;

   // Region an address falls into
   typedef enum logic [1:0] {
      REG_EXT  = 2'd0,
      REG_DCCM = 2'd1,
      REG_PIC  = 2'd2
   } lsu_region_e;

   // Faults found by the address check
   typedef struct packed {
      logic access;
      logic misaligned;
   } lsu_fault_t;

endpackage

`default_nettype wire

/* design/lsu_req_select.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_req_select
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`LSU_ADDR_W-1:0]   exu_lsu_rs1_d,
   input  logic [`LSU_OFFSET_W-1:0] dec_lsu_offset_d,
   input  lsu_pkt_t                 lsu_p,
   input  logic                     dma_dccm_req,
   input  logic [`LSU_ADDR_W-1:0]   dma_mem_addr,
   input  lsu_dma_size_e            dma_mem_sz,
   input  logic                     dma_mem_write,
   input  logic                     flush_dc2_up,
   output logic [`LSU_ADDR_W-1:0]   rs1_dc1,
   output logic [`LSU_OFFSET_W-1:0] offset_dc1,
   output lsu_pkt_t                 lsu_pkt_dc1
);

   lsu_pkt_t                 dma_pkt_d;
   lsu_pkt_t                 lsu_pkt_d;
   logic [`LSU_ADDR_W-1:0]   rs1_d;
   logic [`LSU_OFFSET_W-1:0] offset_d;

   // DMA packet from size code and write flag
   always_comb begin
      dma_pkt_d        = '0;
      dma_pkt_d.valid  = dma_dccm_req;
      dma_pkt_d.dma    = 1'b1;
      dma_pkt_d.unsign = 1'b0;
      dma_pkt_d.store  = dma_mem_write;
      dma_pkt_d.load   = ~dma_mem_write;
      dma_pkt_d.by     = (dma_mem_sz == BYTE);
      dma_pkt_d.half   = (dma_mem_sz == HALF);
      dma_pkt_d.word   = (dma_mem_sz == WORD);
      dma_pkt_d.dword  = (dma_mem_sz == DWORD);
   end

   // DMA wins; a flushed core request does not enter DC1
   always_comb begin
      lsu_pkt_d       = dma_dccm_req ? dma_pkt_d : lsu_p;
      lsu_pkt_d.valid = (lsu_p.valid & ~flush_dc2_up) | dma_dccm_req;
   end

   // DMA address is used as is
   assign rs1_d    = dma_dccm_req ? dma_mem_addr : exu_lsu_rs1_d;
   assign offset_d = dec_lsu_offset_d & ~{`LSU_OFFSET_W{dma_dccm_req}};

   // D to DC1 with the payload loaded every cycle
   always_ff @(posedge clk) begin
      rs1_dc1     <= rs1_d;
      offset_dc1  <= offset_d;
      lsu_pkt_dc1 <= lsu_pkt_d;
      if (!rst_n) begin
         lsu_pkt_dc1.valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* design/lsu_addr_decode.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_addr_decode
   import lsu_pkg::*;
   import lsu_map_pkg::*;
(
   input  logic [`LSU_ADDR_W-1:0]   rs1_dc1,
   input  logic [`LSU_OFFSET_W-1:0] offset_dc1,
   input  lsu_pkt_t                 lsu_pkt_dc1,
   output logic [`LSU_ADDR_W-1:0]   lsu_addr_dc1,
   output logic [`LSU_ADDR_W-1:0]   end_addr_dc1,
   output lsu_region_e              region_dc1,
   output lsu_fault_t               fault_dc1
);

   logic [2:0]       span_dc1;
   lsu_region_e      end_region_dc1;
   logic             unaligned_dc1;

   // Windows are checked by offset from their base
   function automatic lsu_region_e region_of(input logic [`LSU_ADDR_W-1:0] addr);
      logic [`LSU_ADDR_W-1:0] dccm_off;
      logic [`LSU_ADDR_W-1:0] pic_off;
      dccm_off = addr - `LSU_DCCM_BASE;
      pic_off  = addr - `LSU_PIC_BASE;
      if (dccm_off < `LSU_DCCM_SIZE) begin
         region_of = REG_DCCM;
      end else if (pic_off < `LSU_PIC_SIZE) begin
         region_of = REG_PIC;
      end else begin
         region_of = REG_EXT;
      end
   endfunction

   //********************************************************************
   // Start and end address
   //********************************************************************

   // Last byte of the access lies 0, 1, 3 or 7 past the start
   assign span_dc1 = {lsu_pkt_dc1.dword,
                      lsu_pkt_dc1.dword | lsu_pkt_dc1.word,
                      lsu_pkt_dc1.dword | lsu_pkt_dc1.word | lsu_pkt_dc1.half};

   assign lsu_addr_dc1 = rs1_dc1 +
      {{(`LSU_ADDR_W-`LSU_OFFSET_W){offset_dc1[`LSU_OFFSET_W-1]}}, offset_dc1};
   assign end_addr_dc1 = lsu_addr_dc1 + {{(`LSU_ADDR_W-3){1'b0}}, span_dc1};

   //********************************************************************
   // Region and faults
   //********************************************************************

   assign region_dc1     = region_of(lsu_addr_dc1);
   assign end_region_dc1 = region_of(end_addr_dc1);

   assign unaligned_dc1 = (lsu_pkt_dc1.half  & lsu_addr_dc1[0])       |
                          (lsu_pkt_dc1.word  & (|lsu_addr_dc1[1:0])) |
                          (lsu_pkt_dc1.dword & (|lsu_addr_dc1[2:0]));

   // Crossing a window edge, or PIC touched with anything but a word
   assign fault_dc1.access = (end_region_dc1 != region_dc1) |
                             ((region_dc1 == REG_PIC) & ~lsu_pkt_dc1.word);

   // DCCM handles unaligned accesses itself
   assign fault_dc1.misaligned = unaligned_dc1 & (region_dc1 != REG_DCCM);

endmodule

`default_nettype wire

/* lsu_pipe/lsu_pipe.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_pipe
   import lsu_pkg::*;
   import lsu_map_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  lsu_pkt_t               lsu_pkt_dc1,
   input  logic [`LSU_ADDR_W-1:0] lsu_addr_dc1,
   input  logic [`LSU_ADDR_W-1:0] end_addr_dc1,
   input  lsu_region_e            region_dc1,
   input  lsu_fault_t             fault_dc1,
   input  logic                   flush_dc2_up,
   input  logic                   flush_dc3,
   input  logic                   flush_dc4,
   input  logic                   flush_dc5,
   input  logic                   ld_bus_error_dc3,
   output lsu_pkt_t               lsu_pkt_dc3,
   output logic [`LSU_ADDR_W-1:0] lsu_addr_dc3,
   output logic [`LSU_ADDR_W-1:0] end_addr_dc3,
   output lsu_region_e            region_dc3,
   output logic                   lsu_exc_dc2,
   output lsu_error_pkt_t         lsu_error_pkt_dc3,
   output logic                   lsu_commit_dc5,
   output logic [`LSU_ADDR_W-1:0] lsu_addr_dc5
);

   lsu_pkt_t               lsu_pkt_dc2;
   lsu_pkt_t               lsu_pkt_dc4;
   lsu_pkt_t               lsu_pkt_dc5;
   logic                   valid_dc2_in;
   logic                   valid_dc3_in;
   logic                   valid_dc4_in;
   logic                   valid_dc5_in;
   logic [`LSU_ADDR_W-1:0] lsu_addr_dc2;
   logic [`LSU_ADDR_W-1:0] lsu_addr_dc4;
   logic [`LSU_ADDR_W-1:0] end_addr_dc2;
   lsu_region_e            region_dc2;
   lsu_fault_t             fault_dc2;
   lsu_fault_t             fault_dc3;

   // Flushes never kill a DMA packet
   assign valid_dc2_in = lsu_pkt_dc1.valid & ~(flush_dc2_up & ~lsu_pkt_dc1.dma);
   assign valid_dc3_in = lsu_pkt_dc2.valid & ~(flush_dc2_up & ~lsu_pkt_dc2.dma);
   assign valid_dc4_in = lsu_pkt_dc3.valid & ~(flush_dc3 & ~lsu_pkt_dc3.dma);
   assign valid_dc5_in = lsu_pkt_dc4.valid & ~(flush_dc4 & ~lsu_pkt_dc4.dma);

   //********************************************************************
   // Stage registers DC2 to DC5
   //********************************************************************

   always_ff @(posedge clk) begin
      lsu_pkt_dc2       <= lsu_pkt_dc1;
      lsu_pkt_dc3       <= lsu_pkt_dc2;
      lsu_pkt_dc4       <= lsu_pkt_dc3;
      lsu_pkt_dc5       <= lsu_pkt_dc4;
      lsu_pkt_dc2.valid <= valid_dc2_in;
      lsu_pkt_dc3.valid <= valid_dc3_in;
      lsu_pkt_dc4.valid <= valid_dc4_in;
      lsu_pkt_dc5.valid <= valid_dc5_in;
      lsu_addr_dc2      <= lsu_addr_dc1;
      lsu_addr_dc3      <= lsu_addr_dc2;
      lsu_addr_dc4      <= lsu_addr_dc3;
      lsu_addr_dc5      <= lsu_addr_dc4;
      end_addr_dc2      <= end_addr_dc1;
      end_addr_dc3      <= end_addr_dc2;
      region_dc2        <= region_dc1;
      region_dc3        <= region_dc2;
      fault_dc2         <= fault_dc1;
      fault_dc3         <= fault_dc2;
      if (!rst_n) begin
         lsu_pkt_dc2.valid <= 1'b0;
         lsu_pkt_dc3.valid <= 1'b0;
         lsu_pkt_dc4.valid <= 1'b0;
         lsu_pkt_dc5.valid <= 1'b0;
         fault_dc2         <= '0;
         fault_dc3         <= '0;
      end
   end

   //********************************************************************
   // Exceptions and commit
   //********************************************************************

   assign lsu_exc_dc2 = fault_dc2.access | fault_dc2.misaligned;

   assign lsu_error_pkt_dc3.exc_valid =
      (fault_dc3.access | fault_dc3.misaligned | ld_bus_error_dc3) &
      lsu_pkt_dc3.valid & ~lsu_pkt_dc3.dma & ~flush_dc3;
   assign lsu_error_pkt_dc3.inst_type = lsu_pkt_dc3.store;
   // Bus errors report as access faults
   assign lsu_error_pkt_dc3.exc_type  = ~fault_dc3.misaligned;
   assign lsu_error_pkt_dc3.addr      = lsu_addr_dc3;

   // DMA traffic is not retired by the core
   assign lsu_commit_dc5 = lsu_pkt_dc5.valid & (lsu_pkt_dc5.load | lsu_pkt_dc5.store) &
                           ~lsu_pkt_dc5.dma & ~flush_dc5;

endmodule

`default_nettype wire

/* design/lsu_load_format.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_load_format
   import lsu_pkg::*;
   import lsu_map_pkg::*;
(
   input  lsu_pkt_t               lsu_pkt_dc3,
   input  lsu_region_e            region_dc3,
   input  logic [`LSU_ADDR_W-1:0] lsu_ld_data_dc3,
   input  logic [`LSU_ADDR_W-1:0] bus_read_data_dc3,
   output logic [`LSU_ADDR_W-1:0] lsu_result_dc3
);

   logic [`LSU_ADDR_W-1:0] ld_data_fn_dc3;

   // External loads come back over the bus
   assign ld_data_fn_dc3 = (region_dc3 == REG_EXT) ? bus_read_data_dc3 : lsu_ld_data_dc3;

   always_comb begin
      if (lsu_pkt_dc3.by) begin
         lsu_result_dc3 = {{24{ld_data_fn_dc3[7] & ~lsu_pkt_dc3.unsign}},
                           ld_data_fn_dc3[7:0]};
      end else if (lsu_pkt_dc3.half) begin
         lsu_result_dc3 = {{16{ld_data_fn_dc3[15] & ~lsu_pkt_dc3.unsign}},
                           ld_data_fn_dc3[15:0]};
      end else if (lsu_pkt_dc3.word) begin
         lsu_result_dc3 = ld_data_fn_dc3;
      end else begin
         // No 64-bit result path so dword reads as zero
         lsu_result_dc3 = '0;
      end
   end

endmodule

`default_nettype wire

/* design/lsu_ctl_top.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_ctl_top
   import lsu_pkg::*;
   import lsu_map_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`LSU_ADDR_W-1:0]   exu_lsu_rs1_d,
   input  logic [`LSU_OFFSET_W-1:0] dec_lsu_offset_d,
   input  lsu_pkt_t                 lsu_p,
   input  logic                     dma_dccm_req,
   input  logic [`LSU_ADDR_W-1:0]   dma_mem_addr,
   input  lsu_dma_size_e            dma_mem_sz,
   input  logic                     dma_mem_write,
   input  logic                     flush_dc2_up,
   input  logic                     flush_dc3,
   input  logic                     flush_dc4,
   input  logic                     flush_dc5,
   input  logic [`LSU_ADDR_W-1:0]   lsu_ld_data_dc3,
   input  logic [`LSU_ADDR_W-1:0]   bus_read_data_dc3,
   input  logic                     ld_bus_error_dc3,
   output logic [`LSU_ADDR_W-1:0]   lsu_result_dc3,
   output lsu_error_pkt_t           lsu_error_pkt_dc3,
   output logic [`LSU_ADDR_W-1:0]   lsu_addr_dc3,
   output logic [`LSU_ADDR_W-1:0]   end_addr_dc3,
   output logic                     addr_in_dccm_dc3,
   output logic                     addr_in_pic_dc3,
   output logic                     addr_external_dc3,
   output logic                     lsu_exc_dc2,
   output logic                     lsu_commit_dc5,
   output logic [`LSU_ADDR_W-1:0]   lsu_addr_dc5
);

   logic [`LSU_ADDR_W-1:0]   rs1_dc1;
   logic [`LSU_OFFSET_W-1:0] offset_dc1;
   lsu_pkt_t                 lsu_pkt_dc1;
   lsu_pkt_t                 lsu_pkt_dc3;
   logic [`LSU_ADDR_W-1:0]   lsu_addr_dc1;
   logic [`LSU_ADDR_W-1:0]   end_addr_dc1;
   lsu_region_e              region_dc1;
   lsu_region_e              region_dc3;
   lsu_fault_t               fault_dc1;

   lsu_req_select u_lsu_req_select (
      .clk              (clk),
      .rst_n            (rst_n),
      .exu_lsu_rs1_d    (exu_lsu_rs1_d),
      .dec_lsu_offset_d (dec_lsu_offset_d),
      .lsu_p            (lsu_p),
      .dma_dccm_req     (dma_dccm_req),
      .dma_mem_addr     (dma_mem_addr),
      .dma_mem_sz       (dma_mem_sz),
      .dma_mem_write    (dma_mem_write),
      .flush_dc2_up     (flush_dc2_up),
      .rs1_dc1          (rs1_dc1),
      .offset_dc1       (offset_dc1),
      .lsu_pkt_dc1      (lsu_pkt_dc1)
   );

   lsu_addr_decode u_lsu_addr_decode (
      .rs1_dc1      (rs1_dc1),
      .offset_dc1   (offset_dc1),
      .lsu_pkt_dc1  (lsu_pkt_dc1),
      .lsu_addr_dc1 (lsu_addr_dc1),
      .end_addr_dc1 (end_addr_dc1),
      .region_dc1   (region_dc1),
      .fault_dc1    (fault_dc1)
   );

   lsu_pipe u_lsu_pipe (
      .clk               (clk),
      .rst_n             (rst_n),
      .lsu_pkt_dc1       (lsu_pkt_dc1),
      .lsu_addr_dc1      (lsu_addr_dc1),
      .end_addr_dc1      (end_addr_dc1),
      .region_dc1        (region_dc1),
      .fault_dc1         (fault_dc1),
      .flush_dc2_up      (flush_dc2_up),
      .flush_dc3         (flush_dc3),
      .flush_dc4         (flush_dc4),
      .flush_dc5         (flush_dc5),
      .ld_bus_error_dc3  (ld_bus_error_dc3),
      .lsu_pkt_dc3       (lsu_pkt_dc3),
      .lsu_addr_dc3      (lsu_addr_dc3),
      .end_addr_dc3      (end_addr_dc3),
      .region_dc3        (region_dc3),
      .lsu_exc_dc2       (lsu_exc_dc2),
      .lsu_error_pkt_dc3 (lsu_error_pkt_dc3),
      .lsu_commit_dc5    (lsu_commit_dc5),
      .lsu_addr_dc5      (lsu_addr_dc5)
   );

   lsu_load_format u_lsu_load_format (
      .lsu_pkt_dc3       (lsu_pkt_dc3),
      .region_dc3        (region_dc3),
      .lsu_ld_data_dc3   (lsu_ld_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .lsu_result_dc3    (lsu_result_dc3)
   );

   // One-hot region flags for the DC3 consumers
   assign addr_in_dccm_dc3  = (region_dc3 == REG_DCCM);
   assign addr_in_pic_dc3   = (region_dc3 == REG_PIC);
   assign addr_external_dc3 = (region_dc3 == REG_EXT);

endmodule

`default_nettype wire

/* tb/tb_lsu_ctl.sv */
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_ctl
   import lsu_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // Golden file columns in hex
   localparam int max_vec    = 64;
   localparam int num_cols   = 22;
   localparam int col_pkt    = 0;
   localparam int col_rs1    = 1;
   localparam int col_off    = 2;
   localparam int col_dreq   = 3;
   localparam int col_daddr  = 4;
   localparam int col_dsz    = 5;
   localparam int col_dwr    = 6;
   localparam int col_f2     = 7;
   localparam int col_f3     = 8;
   localparam int col_f4     = 9;
   localparam int col_f5     = 10;
   localparam int col_ld     = 11;
   localparam int col_bus    = 12;
   localparam int col_berr   = 13;
   localparam int col_addr   = 14;
   localparam int col_end    = 15;
   localparam int col_result = 16;
   localparam int col_reg    = 17;
   localparam int col_exc2   = 18;
   localparam int col_excv   = 19;
   localparam int col_etype  = 20;
   localparam int col_commit = 21;

   logic                     clk;
   logic                     rst_n;
   logic [`LSU_ADDR_W-1:0]   exu_lsu_rs1_d;
   logic [`LSU_OFFSET_W-1:0] dec_lsu_offset_d;
   lsu_pkt_t                 lsu_p;
   logic                     dma_dccm_req;
   logic [`LSU_ADDR_W-1:0]   dma_mem_addr;
   lsu_dma_size_e            dma_mem_sz;
   logic                     dma_mem_write;
   logic                     flush_dc2_up;
   logic                     flush_dc3;
   logic                     flush_dc4;
   logic                     flush_dc5;
   logic [`LSU_ADDR_W-1:0]   lsu_ld_data_dc3;
   logic [`LSU_ADDR_W-1:0]   bus_read_data_dc3;
   logic                     ld_bus_error_dc3;
   logic [`LSU_ADDR_W-1:0]   lsu_result_dc3;
   lsu_error_pkt_t           lsu_error_pkt_dc3;
   logic [`LSU_ADDR_W-1:0]   lsu_addr_dc3;
   logic [`LSU_ADDR_W-1:0]   end_addr_dc3;
   logic                     addr_in_dccm_dc3;
   logic                     addr_in_pic_dc3;
   logic                     addr_external_dc3;
   logic                     lsu_exc_dc2;
   logic                     lsu_commit_dc5;
   logic [`LSU_ADDR_W-1:0]   lsu_addr_dc5;

   logic [31:0] vec [0:max_vec-1][0:num_cols-1];
   int          n_vec = 0;
   logic        loaded = 1'b0;

   lsu_ctl_top u_lsu_ctl_top (.*);

   always begin
      #50 clk = ~clk;
   end

   // ********************************************************************
   // Failure reporting and compare tasks
   // ********************************************************************

   task automatic fail_mismatch(input string what);
      $display("mismatch at %0d ns: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at first mismatch");
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0d ns: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "Run aborted");
   endtask

   task automatic check_word(input string name, input logic [`LSU_ADDR_W-1:0] got,
                             input logic [`LSU_ADDR_W-1:0] exp);
      if (got !== exp) begin
         fail_mismatch($sformatf("%s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_mismatch($sformatf("%s got %b expected %b", name, got, exp));
      end
   endtask

   // exc_type only means something for a reported exception
   task automatic check_err(input string name, input lsu_error_pkt_t got,
                            input lsu_error_pkt_t exp);
      if (got.exc_valid !== exp.exc_valid) begin
         fail_mismatch($sformatf("%s exc_valid got %b expected %b", name,
                                 got.exc_valid, exp.exc_valid));
      end else if (got.inst_type !== exp.inst_type) begin
         fail_mismatch($sformatf("%s inst_type got %b expected %b", name,
                                 got.inst_type, exp.inst_type));
      end else if (got.addr !== exp.addr) begin
         fail_mismatch($sformatf("%s addr got %h expected %h", name, got.addr, exp.addr));
      end else if (exp.exc_valid && (got.exc_type !== exp.exc_type)) begin
         fail_mismatch($sformatf("%s exc_type got %b expected %b", name,
                                 got.exc_type, exp.exc_type));
      end
   endtask

   function automatic bit in_range(input int v);
      in_range = (v >= 0) && (v < n_vec);
   endfunction

   // ********************************************************************
   // Golden file and stimulus
   // ********************************************************************

   task automatic read_vectors();
      int              fd;
      int              code;
      bit              done;
      reg [8*256-1:0]  hdr;
      fd   = $fopen("tb/lsu_ctl_golden.txt", "r");
      done = 1'b0;
      if (fd == 0) begin
         report_failure("cannot open tb/lsu_ctl_golden.txt");
      end else if (($fgets(hdr, fd) == 0) || ($fgets(hdr, fd) == 0)) begin
         report_failure("cannot read the header lines of the golden file");
      end else begin
         while (!done) begin
            if (n_vec == max_vec) begin
               report_failure("golden file holds more vectors than the testbench can store");
            end else begin
               code = $fscanf(fd,
                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                  vec[n_vec][0], vec[n_vec][1], vec[n_vec][2], vec[n_vec][3],
                  vec[n_vec][4], vec[n_vec][5], vec[n_vec][6], vec[n_vec][7],
                  vec[n_vec][8], vec[n_vec][9], vec[n_vec][10], vec[n_vec][11],
                  vec[n_vec][12], vec[n_vec][13], vec[n_vec][14], vec[n_vec][15],
                  vec[n_vec][16], vec[n_vec][17], vec[n_vec][18], vec[n_vec][19],
                  vec[n_vec][20], vec[n_vec][21]);
               if (code == num_cols) begin
                  n_vec++;
               end else if ($feof(fd) != 0) begin
                  done = 1'b1;
               end else begin
                  report_failure($sformatf("golden file line %0d cannot be read", n_vec + 3));
               end
            end
         end
         $fclose(fd);
         if (n_vec == 0) begin
            report_failure("golden file holds no vectors");
         end
      end
   endtask

   // Vector c sits at D in cycle c, so its DC3 is cycle c+3 and DC5 is c+5
   task automatic drive_cycle(input int c);
      int v3;
      int v4;
      int v5;
      v3 = c - 3;
      v4 = c - 4;
      v5 = c - 5;
      if (in_range(c)) begin
         lsu_p            <= lsu_pkt_t'(vec[c][col_pkt][8:0]);
         exu_lsu_rs1_d    <= vec[c][col_rs1];
         dec_lsu_offset_d <= vec[c][col_off][`LSU_OFFSET_W-1:0];
         dma_dccm_req     <= vec[c][col_dreq][0];
         dma_mem_addr     <= vec[c][col_daddr];
         dma_mem_sz       <= lsu_dma_size_e'(vec[c][col_dsz][2:0]);
         dma_mem_write    <= vec[c][col_dwr][0];
         flush_dc2_up     <= vec[c][col_f2][0];
      end else begin
         lsu_p            <= '0;
         exu_lsu_rs1_d    <= '0;
         dec_lsu_offset_d <= '0;
         dma_dccm_req     <= 1'b0;
         dma_mem_addr     <= '0;
         dma_mem_sz       <= BYTE;
         dma_mem_write    <= 1'b0;
         flush_dc2_up     <= 1'b0;
      end
      lsu_ld_data_dc3   <= in_range(v3) ? vec[v3][col_ld] : '0;
      bus_read_data_dc3 <= in_range(v3) ? vec[v3][col_bus] : '0;
      ld_bus_error_dc3  <= in_range(v3) ? vec[v3][col_berr][0] : 1'b0;
      flush_dc3         <= in_range(v3) ? vec[v3][col_f3][0] : 1'b0;
      flush_dc4         <= in_range(v4) ? vec[v4][col_f4][0] : 1'b0;
      flush_dc5         <= in_range(v5) ? vec[v5][col_f5][0] : 1'b0;
   endtask

   task automatic check_cycle(input int c);
      int             v2;
      int             v3;
      int             v5;
      lsu_error_pkt_t exp_err;
      logic           exp_commit;
      v2 = c - 2;
      v3 = c - 3;
      v5 = c - 5;
      if (in_range(v2)) begin
         check_bit($sformatf("vector %0d lsu_exc_dc2", v2), lsu_exc_dc2, vec[v2][col_exc2][0]);
      end
      if (in_range(v3)) begin
         check_word($sformatf("vector %0d lsu_addr_dc3", v3), lsu_addr_dc3, vec[v3][col_addr]);
         check_word($sformatf("vector %0d end_addr_dc3", v3), end_addr_dc3, vec[v3][col_end]);
         check_word($sformatf("vector %0d lsu_result_dc3", v3), lsu_result_dc3,
                    vec[v3][col_result]);
         check_bit($sformatf("vector %0d addr_in_dccm_dc3", v3), addr_in_dccm_dc3,
                   vec[v3][col_reg][2]);
         check_bit($sformatf("vector %0d addr_in_pic_dc3", v3), addr_in_pic_dc3,
                   vec[v3][col_reg][1]);
         check_bit($sformatf("vector %0d addr_external_dc3", v3), addr_external_dc3,
                   vec[v3][col_reg][0]);
         // A store is reported as inst_type 1
         exp_err.exc_valid = vec[v3][col_excv][0];
         exp_err.inst_type = vec[v3][col_dreq][0] ? vec[v3][col_dwr][0] : vec[v3][col_pkt][3];
         exp_err.exc_type  = vec[v3][col_etype][0];
         exp_err.addr      = vec[v3][col_addr];
         check_err($sformatf("vector %0d lsu_error_pkt_dc3", v3), lsu_error_pkt_dc3, exp_err);
      end else begin
         check_bit("empty DC3 exc_valid", lsu_error_pkt_dc3.exc_valid, 1'b0);
      end
      exp_commit = in_range(v5) ? vec[v5][col_commit][0] : 1'b0;
      check_bit($sformatf("cycle %0d lsu_commit_dc5", c), lsu_commit_dc5, exp_commit);
      if (in_range(v5)) begin
         check_word($sformatf("vector %0d lsu_addr_dc5", v5), lsu_addr_dc5, vec[v5][col_addr]);
      end
   endtask

   // ********************************************************************
   // Main sequence and watchdog
   // ********************************************************************

   initial begin : main_seq
      int c;
      clk   = 1'b0;
      rst_n = 1'b0;
      drive_cycle(-10);
      read_vectors();
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      // Drain five more cycles so the last vector reaches DC5
      for (c = 0; c < n_vec + 6; c++) begin
         drive_cycle(c);
         @(negedge clk);
         check_cycle(c);
         @(posedge clk);
      end
      $display("Simulation PASSED");
      $finish;
   end

   initial begin : watchdog
      wait (loaded === 1'b1);
      #((n_vec + 20) * 100);
      report_failure("timeout, the vectors did not finish in the allowed time");
   end

endmodule

`default_nettype wire

/* tb/lsu_ctl_golden.txt */
# pkt rs1 off dma_req dma_addr dma_sz dma_wr flush_dc2_up flush_dc3 flush_dc4 flush_dc5 ld bus berr
# then expected: addr end_addr result region(4 dccm 2 pic 1 ext) exc_dc2 exc_valid exc_type commit
031 F0040100 004 0 00000000 0 0 0 0 0 0 12345685 DEADBEEF 0 F0040104 F0040104 FFFFFF85 4 0 0 0 1
035 F0040100 FFC 0 00000000 0 0 0 0 0 0 111122F0 DEADBEEF 0 F00400FC F00400FC 000000F0 4 0 0 0 1
051 F0041000 002 0 00000000 0 0 0 0 0 0 00009234 DEADBEEF 0 F0041002 F0041003 FFFF9234 4 0 0 0 1
055 00001000 010 0 00000000 0 0 0 0 0 0 11111111 7777C001 0 00001010 00001011 0000C001 1 0 0 0 1
091 20000000 7FC 0 00000000 0 0 0 0 0 0 11111111 CAFEF00D 0 200007FC 200007FF CAFEF00D 1 0 0 0 1
031 20000000 801 0 00000000 0 0 0 0 0 0 11111111 1234567F 0 1FFFF801 1FFFF801 0000007F 1 0 0 0 1
091 30000002 000 0 00000000 0 0 0 0 0 0 11111111 0BADF00D 0 30000002 30000005 0BADF00D 1 1 1 0 1
091 F004FFFC 002 0 00000000 0 0 0 0 0 0 89ABCDEF DEADBEEF 0 F004FFFE F0050001 89ABCDEF 4 1 1 1 1
051 F00C0000 010 0 00000000 0 0 0 0 0 0 00008001 DEADBEEF 0 F00C0010 F00C0011 FFFF8001 2 1 1 1 1
091 F00C0000 020 0 00000000 0 0 0 0 0 0 000000FF DEADBEEF 0 F00C0020 F00C0023 000000FF 2 0 0 0 1
091 40000000 000 0 00000000 0 0 0 0 0 0 11111111 00000000 1 40000000 40000003 00000000 1 0 1 1 1
091 F0040000 001 0 00000000 0 0 0 0 0 0 01020304 DEADBEEF 0 F0040001 F0040004 01020304 4 0 0 0 1
089 F0040200 000 0 00000000 0 0 0 0 0 0 00000000 DEADBEEF 0 F0040200 F0040203 00000000 4 0 0 0 1
049 50000001 000 0 00000000 0 0 0 1 0 0 00000000 00000000 0 50000001 50000002 00000000 1 1 0 0 0
091 F0040300 000 0 00000000 0 0 0 0 1 0 55AA55AA DEADBEEF 0 F0040300 F0040303 55AA55AA 4 0 0 0 0
091 F0040400 000 0 00000000 0 0 0 0 0 1 00000000 DEADBEEF 0 F0040400 F0040403 00000000 4 0 0 0 0
031 00000000 123 1 F0040800 1 0 0 0 0 0 0000F00F DEADBEEF 0 F0040800 F0040801 FFFFF00F 4 0 0 0 0
000 00000000 000 1 F0040810 2 1 0 1 1 1 13572468 DEADBEEF 0 F0040810 F0040813 13572468 4 0 0 0 0
000 00000000 000 1 F00C0002 1 0 0 0 0 0 00007FFF DEADBEEF 0 F00C0002 F00C0003 00007FFF 2 1 0 0 0
091 F0040500 000 0 00000000 0 0 1 0 0 0 11223344 DEADBEEF 0 F0040500 F0040503 11223344 4 0 0 0 0
000 00000000 000 1 F0040003 0 0 1 0 0 0 000000C3 DEADBEEF 0 F0040003 F0040003 FFFFFFC3 4 0 0 0 0
000 00000000 000 1 60000000 3 0 0 0 0 0 00000000 FFFFFFFF 0 60000000 60000007 00000000 1 0 0 0 0
089 70000000 008 0 00000000 0 0 0 0 0 0 00000000 00000000 0 70000008 7000000B 00000000 1 0 0 0 1
055 F004FFF0 00E 0 00000000 0 0 0 0 0 0 8000ABCD DEADBEEF 0 F004FFFE F004FFFF 0000ABCD 4 0 0 0 1

/* compile.f */
+incdir+common
common/lsu_pkg.sv
common/lsu_map_pkg.sv
design/lsu_req_select.sv
design/lsu_addr_decode.sv
lsu_pipe/lsu_pipe.sv
design/lsu_load_format.sv
design/lsu_ctl_top.sv
tb/tb_lsu_ctl.sv

/* Bender.yml */
package:
  name: lsu_ctl

sources:
  - include_dirs:
      - common
    files:
      - common/lsu_pkg.sv
      - common/lsu_map_pkg.sv
      - design/lsu_req_select.sv
      - design/lsu_addr_decode.sv
      - lsu_pipe/lsu_pipe.sv
      - design/lsu_load_format.sv
      - design/lsu_ctl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_lsu_ctl.sv
